// File: compile.f
+incdir+bench
verilog/bus_pkg.sv
verilog/port_if.sv
verilog/target_if.sv
verilog/core_port.sv
verilog/bus_arbiter.sv
verilog/dram_ctrl.sv
verilog/io_regs.sv
verilog/bus_subsystem.sv
bench/tb_bus_subsystem.sv

// File: Makefile
# Verilator build, run, lint and clean for the shared memory path

VERILATOR ?= verilator
TOP       ?= tb_bus_subsystem
RTL_TOP   ?= bus_subsystem
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTS PASSED

RTL_SRCS ?= verilog/bus_pkg.sv verilog/port_if.sv verilog/target_if.sv \
            verilog/core_port.sv verilog/bus_arbiter.sv verilog/dram_ctrl.sv \
            verilog/io_regs.sv verilog/bus_subsystem.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_model.svh
/* reference model: DRAM and IO register images, lane merge and
   extract, expected round-robin choice */

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] dram_model [DRAM_WORDS];
bit          dram_written [DRAM_WORDS];
logic [31:0] io_model [IO_REGS];
int          io_count;
bit          rr_last;

// lowest byte lane touched, halves are aligned
function automatic int lane_base(acc_size_t size, logic [31:0] addr);
    case (size)
        size_byte: return int'(addr[1:0]);
        size_half: return addr[1] ? 2 : 0;
        default:   return 0;
    endcase
endfunction

function automatic int lane_count(acc_size_t size);
    case (size)
        size_byte: return 1;
        size_half: return 2;
        default:   return 4;
    endcase
endfunction

function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] wdata,
                                            acc_size_t size, logic [31:0] addr);
    logic [31:0] word;
    int          base;
    word = old;
    base = lane_base(size, addr);
    for (int i = 0; i < lane_count(size); i++) begin
        word[8*(base+i) +: 8] = wdata[8*i +: 8];
    end
    return word;
endfunction

// right-aligned, upper bytes zero
function automatic logic [31:0] extract_lanes(logic [31:0] word, acc_size_t size,
                                              logic [31:0] addr);
    logic [31:0] res;
    int          base;
    res  = '0;
    base = lane_base(size, addr);
    for (int i = 0; i < lane_count(size); i++) begin
        res[8*i +: 8] = word[8*(base+i) +: 8];
    end
    return res;
endfunction

function automatic void model_write(target_t tgt, acc_size_t size, logic [31:0] addr,
                                    logic [31:0] wdata);
    int idx;
    idx = int'(addr[31:2]);
    if (tgt == tgt_dram) begin
        idx = idx % DRAM_WORDS;
        dram_model[idx] = merge_lanes(dram_model[idx], wdata, size, addr);
        if (size == size_word) begin
            dram_written[idx] = 1'b1;
        end
    end else if (idx < IO_REGS) begin
        // IO registers take the full word
        io_model[idx] = wdata;
        io_count++;
    end
endfunction

function automatic logic [31:0] model_read(target_t tgt, acc_size_t size, logic [31:0] addr);
    int idx;
    idx = int'(addr[31:2]);
    if (tgt == tgt_dram) begin
        return extract_lanes(dram_model[idx % DRAM_WORDS], size, addr);
    end else if (idx < IO_REGS) begin
        return io_model[idx];
    end else if (idx == IO_REGS) begin
        return 32'(io_count);
    end
    return '0;
endfunction

// next port served, the other one on a tie
function automatic bit rr_choose(bit p0, bit p1);
    bit pick;
    if (p0 && p1) begin
        pick = !rr_last;
    end else begin
        pick = p1;
    end
    rr_last = pick;
    return pick;
endfunction

`endif

// File: bench/tb_bus_subsystem.sv
/* testbench for the shared memory path: reset, word, sized, round-robin,
   concurrent and IO counter tests against a reference model */

`timescale 1ns/100ps

module tb_bus_subsystem import bus_pkg::*; ();

    localparam int DRAM_WORDS   = 256;
    localparam int DRAM_LATENCY = 3;
    localparam int IO_REGS      = 8;
    localparam int half_words   = DRAM_WORDS / 2;
    localparam int n_word       = 24;
    localparam int n_sized      = 24;
    localparam int n_pairs      = 6;
    localparam int n_conc       = 40;
    localparam int n_io_max     = 12;
    localparam int n_requests   = (IO_REGS + 1) + 2 * n_word + 2 * n_sized
                                  + 3 * n_pairs + 2 * n_conc + n_io_max + 3;
    localparam int watchdog_ns  = n_requests * (DRAM_LATENCY + 8) * 20 + 16 * 20;

    logic              CLK;
    logic              rst_n;
    logic              c0_rd;
    logic              c0_wr;
    target_t           c0_target;
    acc_size_t         c0_size;
    logic [addr_w-1:0] c0_addr;
    logic [xlen-1:0]   c0_wdata;
    logic [xlen-1:0]   c0_rdata;
    logic              c0_busy;
    logic              c1_rd;
    logic              c1_wr;
    target_t           c1_target;
    acc_size_t         c1_size;
    logic [addr_w-1:0] c1_addr;
    logic [xlen-1:0]   c1_wdata;
    logic [xlen-1:0]   c1_rdata;
    logic              c1_busy;
    logic              grant;

    integer            seed;
    int                errors;
    int                checks;

    `include "tb_model.svh"

    bus_subsystem #(
        .DRAM_WORDS   (DRAM_WORDS),
        .DRAM_LATENCY (DRAM_LATENCY),
        .IO_REGS      (IO_REGS)
    ) i_bus_subsystem (.*);

    always #10 CLK = ~CLK;

    initial begin
        #(watchdog_ns);
        $display("timeout: not every request completed in the expected time");
        $display("TESTS FAILED");
        $finish;
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic port_busy(int core);
        return (core == 0) ? c0_busy : c1_busy;
    endfunction

    function automatic logic [31:0] port_rdata(int core);
        return (core == 0) ? c0_rdata : c1_rdata;
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic drive_req(int core, logic rd, logic wr, target_t tgt, acc_size_t size,
                             logic [31:0] addr, logic [31:0] wdata);
        if (core == 0) begin
            c0_rd     = rd;
            c0_wr     = wr;
            c0_target = tgt;
            c0_size   = size;
            c0_addr   = addr;
            c0_wdata  = wdata;
        end else begin
            c1_rd     = rd;
            c1_wr     = wr;
            c1_target = tgt;
            c1_size   = size;
            c1_addr   = addr;
            c1_wdata  = wdata;
        end
    endtask

    // one request on a core port with its read checked once busy falls
    task automatic access(int core, bit write, target_t tgt, acc_size_t size,
                          logic [31:0] addr, logic [31:0] wdata);
        string name;
        name = (core == 0) ? "c0_rdata" : "c1_rdata";
        // tracker only meaningful while one core is active
        void'(rr_choose(core == 0, core == 1));
        @(negedge CLK);
        drive_req(core, !write, write, tgt, size, addr, wdata);
        @(negedge CLK);
        drive_req(core, 1'b0, 1'b0, tgt, size, addr, wdata);
        while (port_busy(core)) begin
            @(negedge CLK);
        end
        if (write) begin
            model_write(tgt, size, addr, wdata);
        end else begin
            check_value(name, model_read(tgt, size, addr), port_rdata(core));
        end
    endtask

    // each core keeps to its own DRAM half and IO register half
    task automatic random_traffic(int core);
        int        idx;
        bit        write;
        acc_size_t size;
        for (int i = 0; i < n_conc; i++) begin
            write = rand_below(2) == 1;
            size  = acc_size_t'(rand_below(3));
            if (rand_below(2) == 0) begin
                idx = core * half_words + rand_below(half_words);
                if (!dram_written[idx]) begin
                    write = 1'b1;
                    size  = size_word;
                end
                access(core, write, tgt_dram, size, 32'(idx * 4 + rand_below(4)),
                       $random(seed));
            end else begin
                idx = core * (IO_REGS / 2) + rand_below(IO_REGS / 2);
                access(core, write, tgt_io, size, 32'(idx * 4), $random(seed));
            end
        end
    endtask

    task automatic report_test(string name, int first_err);
        $display("test %s: %0d errors", name, errors - first_err);
    endtask

    initial begin
        int          idx;
        int          first_err;
        int          n_io;
        int          wq[$];
        bit          first;
        acc_size_t   size;
        logic [31:0] wd0;
        logic [31:0] wd1;
        seed   = 24;
        errors = 0;
        checks = 0;
        CLK    = 1'b0;
        rst_n  = 1'b0;
        drive_req(0, 1'b0, 1'b0, tgt_dram, size_word, '0, '0);
        drive_req(1, 1'b0, 1'b0, tgt_dram, size_word, '0, '0);
        for (int i = 0; i < IO_REGS; i++) begin
            io_model[i] = '0;
        end
        io_count = 0;
        rr_last  = 1'b0;
        repeat (16) @(negedge CLK);
        rst_n = 1'b1;

        first_err = errors;
        check_value("c0_busy", 0, c0_busy);
        check_value("c1_busy", 0, c1_busy);
        check_value("grant", 0, grant);
        for (int i = 0; i <= IO_REGS; i++) begin
            access(0, 1'b0, tgt_io, size_word, 32'(i * 4), '0);
        end
        report_test("after reset", first_err);

        first_err = errors;
        for (int i = 0; i < n_word; i++) begin
            idx = rand_below(half_words);
            wq.push_back(idx);
            access(0, 1'b1, tgt_dram, size_word, 32'(idx * 4), $random(seed));
        end
        for (int i = 0; i < n_word; i++) begin
            idx = wq[rand_below(wq.size())];
            access(0, 1'b0, tgt_dram, size_word, 32'(idx * 4), '0);
        end
        report_test("single-core word traffic", first_err);

        // byte and half writes land only on words already written in full
        first_err = errors;
        for (int i = 0; i < n_sized; i++) begin
            idx  = wq[rand_below(wq.size())];
            size = acc_size_t'(rand_below(2));
            access(0, 1'b1, tgt_dram, size, 32'(idx * 4 + rand_below(4)), $random(seed));
            idx  = wq[rand_below(wq.size())];
            size = acc_size_t'(rand_below(3));
            access(0, 1'b0, tgt_dram, size, 32'(idx * 4 + rand_below(4)), '0);
        end
        report_test("sized accesses", first_err);

        // a solo read by the first core steers the next tie the other way
        first_err = errors;
        for (int i = 0; i < n_pairs; i++) begin
            first = rr_choose(1'b1, 1'b1);
            idx   = rand_below(half_words);
            wd0   = $random(seed);
            wd1   = $random(seed);
            @(negedge CLK);
            drive_req(0, 1'b0, 1'b1, tgt_dram, size_word, 32'(idx * 4), wd0);
            drive_req(1, 1'b0, 1'b1, tgt_dram, size_word, 32'((idx + half_words) * 4), wd1);
            @(negedge CLK);
            drive_req(0, 1'b0, 1'b0, tgt_dram, size_word, '0, '0);
            drive_req(1, 1'b0, 1'b0, tgt_dram, size_word, '0, '0);
            @(negedge CLK);
            check_value("grant", 32'(first), 32'(grant));
            while (c0_busy && c1_busy) begin
                @(negedge CLK);
            end
            check_value(first ? "c1_busy" : "c0_busy", 0, port_busy(first));
            check_value(first ? "c0_busy" : "c1_busy", 1, port_busy(!first));
            void'(rr_choose(first, !first));
            while (c0_busy || c1_busy) begin
                @(negedge CLK);
            end
            model_write(tgt_dram, size_word, 32'(idx * 4), wd0);
            model_write(tgt_dram, size_word, 32'((idx + half_words) * 4), wd1);
            access(first, 1'b0, tgt_dram, size_word, 32'((idx + first * half_words) * 4), '0);
        end
        report_test("round-robin", first_err);

        first_err = errors;
        fork
            random_traffic(0);
            random_traffic(1);
        join
        report_test("concurrent random traffic", first_err);

        first_err = errors;
        n_io = 1 + rand_below(n_io_max);
        for (int i = 0; i < n_io; i++) begin
            idx = rand_below(IO_REGS);
            access(rand_below(2), 1'b1, tgt_io, size_word, 32'(idx * 4), $random(seed));
        end
        // counter itself and the address past it take no write
        access(0, 1'b1, tgt_io, size_word, 32'(IO_REGS * 4), $random(seed));
        access(1, 1'b1, tgt_io, size_word, 32'((IO_REGS + 1) * 4), $random(seed));
        access(1, 1'b0, tgt_io, size_word, 32'(IO_REGS * 4), '0);
        report_test("IO write counter", first_err);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/bus_subsystem.sv
/* shared memory path top: two core ports, arbiter, DRAM and IO targets */

`timescale 1ns/100ps

module bus_subsystem import bus_pkg::*; #(
    parameter int DRAM_WORDS   = 256,
    parameter int DRAM_LATENCY = 3,
    parameter int IO_REGS      = 8
) (
    input  logic              CLK,
    input  logic              rst_n,

    input  logic              c0_rd,
    input  logic              c0_wr,
    input  target_t           c0_target,
    input  acc_size_t         c0_size,
    input  logic [addr_w-1:0] c0_addr,
    input  logic [xlen-1:0]   c0_wdata,
    output logic [xlen-1:0]   c0_rdata,
    output logic              c0_busy,

    input  logic              c1_rd,
    input  logic              c1_wr,
    input  target_t           c1_target,
    input  acc_size_t         c1_size,
    input  logic [addr_w-1:0] c1_addr,
    input  logic [xlen-1:0]   c1_wdata,
    output logic [xlen-1:0]   c1_rdata,
    output logic              c1_busy,

    output logic              grant
);

    port_if   port0_if ();
    port_if   port1_if ();
    target_if dram_if ();
    target_if io_if ();

    core_port u_port0 (
        .CLK    (CLK),
        .rst_n  (rst_n),
        .rd     (c0_rd),
        .wr     (c0_wr),
        .target (c0_target),
        .size   (c0_size),
        .addr   (c0_addr),
        .wdata  (c0_wdata),
        .rdata  (c0_rdata),
        .busy   (c0_busy),
        .bus    (port0_if.front)
    );

    core_port u_port1 (
        .CLK    (CLK),
        .rst_n  (rst_n),
        .rd     (c1_rd),
        .wr     (c1_wr),
        .target (c1_target),
        .size   (c1_size),
        .addr   (c1_addr),
        .wdata  (c1_wdata),
        .rdata  (c1_rdata),
        .busy   (c1_busy),
        .bus    (port1_if.front)
    );

    bus_arbiter u_arbiter (
        .CLK   (CLK),
        .rst_n (rst_n),
        .p0    (port0_if.arb),
        .p1    (port1_if.arb),
        .dram  (dram_if.master),
        .io    (io_if.master),
        .grant (grant)
    );

    dram_ctrl #(
        .DRAM_WORDS   (DRAM_WORDS),
        .DRAM_LATENCY (DRAM_LATENCY)
    ) u_dram (
        .CLK   (CLK),
        .rst_n (rst_n),
        .bus   (dram_if.slave)
    );

    io_regs #(
        .IO_REGS (IO_REGS)
    ) u_io (
        .CLK   (CLK),
        .rst_n (rst_n),
        .bus   (io_if.slave)
    );

endmodule

// File: verilog/io_regs.sv
/* IO scratch registers plus a read-only count of register writes */

`timescale 1ns/100ps

module io_regs import bus_pkg::*; #(
    parameter int IO_REGS = 8
) (
    input  logic    CLK,
    input  logic    rst_n,
    target_if.slave bus
);

    localparam int idx_w = (IO_REGS > 1) ? $clog2(IO_REGS) : 1;

    logic [xlen-1:0]   regs [IO_REGS];
    logic [xlen-1:0]   wcount;
    logic [xlen-1:0]   rdata_q;
    logic [addr_w-3:0] word_addr;
    logic [idx_w-1:0]  reg_idx;
    logic              in_regs;
    logic              is_count;
    logic              start;
    logic              busy;
    logic              tick;

    assign word_addr = bus.addr[addr_w-1:2];
    assign reg_idx   = word_addr[idx_w-1:0];
    assign in_regs   = word_addr < (addr_w-2)'(IO_REGS);
    // counter sits one past the last register
    assign is_count  = word_addr == (addr_w-2)'(IO_REGS);
    assign start     = !busy && (bus.le || bus.we);

    // full-width writes, size ignored
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < IO_REGS; i++) begin
                regs[i] <= '0;
            end
            wcount <= '0;
        end else if (start && bus.we && in_regs) begin
            regs[reg_idx] <= bus.wdata;
            wcount        <= wcount + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (start && bus.le) begin
            if (in_regs) begin
                rdata_q <= regs[reg_idx];
            end else if (is_count) begin
                rdata_q <= wcount;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    // two-cycle busy
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            tick <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            tick <= 1'b0;
        end else if (busy) begin
            if (tick) begin
                busy <= 1'b0;
            end else begin
                tick <= 1'b1;
            end
        end
    end

    assign bus.busy  = busy;
    assign bus.rdata = rdata_q;

endmodule

// File: verilog/dram_ctrl.sv
/* word-organised DRAM model with byte lanes, sized read extraction
   and a fixed busy period per access */

`timescale 1ns/100ps

module dram_ctrl import bus_pkg::*; #(
    parameter int DRAM_WORDS   = 256,
    parameter int DRAM_LATENCY = 3
) (
    input  logic    CLK,
    input  logic    rst_n,
    target_if.slave bus
);

    localparam int idx_w = (DRAM_WORDS > 1) ? $clog2(DRAM_WORDS) : 1;
    localparam int cnt_w = $clog2(DRAM_LATENCY + 1);

    logic [xlen-1:0]   mem [DRAM_WORDS];
    logic [addr_w-3:0] word_addr;
    logic [idx_w-1:0]  word_idx;
    logic [1:0]        lane_off;
    logic [lane_w-1:0] lane_mask;
    logic [xlen-1:0]   wdata_sh;
    logic [xlen-1:0]   word_sh;
    logic [xlen-1:0]   rd_ext;
    logic [xlen-1:0]   rdata_q;
    logic [cnt_w-1:0]  cnt;
    logic              busy;
    logic              start;

    assign word_addr = bus.addr[addr_w-1:2];
    assign word_idx  = idx_w'(word_addr % (addr_w-2)'(DRAM_WORDS));

    // lane offset and mask, half and word stay aligned
    always_comb begin
        case (bus.size)
            size_byte: begin
                lane_off  = bus.addr[1:0];
                lane_mask = lane_w'(1) << bus.addr[1:0];
            end
            size_half: begin
                lane_off  = {bus.addr[1], 1'b0};
                lane_mask = lane_w'(3) << {bus.addr[1], 1'b0};
            end
            default: begin
                lane_off  = 2'b00;
                lane_mask = '1;
            end
        endcase
    end

    assign wdata_sh = bus.wdata << {lane_off, 3'b000};
    assign word_sh  = mem[word_idx] >> {lane_off, 3'b000};

    // right-aligned, zero-extended
    always_comb begin
        case (bus.size)
            size_byte: rd_ext = xlen'(word_sh[7:0]);
            size_half: rd_ext = xlen'(word_sh[15:0]);
            default:   rd_ext = word_sh;
        endcase
    end

    assign start = !busy && (bus.le || bus.we);

    always_ff @(posedge CLK) begin
        if (start && bus.we) begin
            for (int i = 0; i < lane_w; i++) begin
                if (lane_mask[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata_sh[8*i +: 8];
                end
            end
        end
        if (start && bus.le) begin
            rdata_q <= rd_ext;
        end
    end

    // busy for DRAM_LATENCY cycles
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= cnt_w'(DRAM_LATENCY - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign bus.busy  = busy;
    assign bus.rdata = rdata_q;

endmodule

// File: verilog/bus_arbiter.sv
/* round-robin bus arbiter for two core ports and the two-phase
   strobe/busy transfer onto the DRAM and IO targets */

`timescale 1ns/100ps

module bus_arbiter import bus_pkg::*; (
    input  logic     CLK,
    input  logic     rst_n,
    port_if.arb      p0,
    port_if.arb      p1,
    target_if.master dram,
    target_if.master io,
    output logic     grant
);

    arb_state_t        state;
    logic              last_served;
    logic              any_pend;
    logic              pick;
    logic              tgt_busy;
    logic [xlen-1:0]   tgt_rdata;
    logic              issue_rd;
    logic              issue_wr;

    // request copied from the chosen port
    logic              req_write;
    target_t           req_target;
    acc_size_t         req_size;
    logic [addr_w-1:0] req_addr;
    logic [xlen-1:0]   req_wdata;
    logic [xlen-1:0]   req_rdata;

    assign any_pend = p0.pend || p1.pend;

    // on a tie the port not served last goes first
    always_comb begin
        if (p0.pend && p1.pend) begin
            pick = ~last_served;
        end else begin
            pick = p1.pend;
        end
    end

    // busy and data of the selected target
    assign tgt_busy  = (req_target == tgt_dram) ? dram.busy : io.busy;
    assign tgt_rdata = (req_target == tgt_dram) ? dram.rdata : io.rdata;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state       <= arb_idle;
            last_served <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (any_pend) begin
                        state       <= arb_issue;
                        last_served <= pick;
                    end
                end
                arb_issue: begin
                    if (tgt_busy) begin
                        state <= arb_wait;
                    end
                end
                arb_wait: begin
                    if (!tgt_busy) begin
                        state <= arb_done;
                    end
                end
                arb_done: begin
                    state <= arb_idle;
                end
                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == arb_idle && any_pend) begin
            req_write  <= pick ? p1.is_write : p0.is_write;
            req_target <= pick ? p1.target : p0.target;
            req_size   <= pick ? p1.size : p0.size;
            req_addr   <= pick ? p1.addr : p0.addr;
            req_wdata  <= pick ? p1.wdata : p0.wdata;
        end
        // collect data as busy falls
        if (state == arb_wait && !tgt_busy) begin
            req_rdata <= tgt_rdata;
        end
    end

    // strobe only while issuing, routed to one target
    assign issue_rd = (state == arb_issue) && !req_write;
    assign issue_wr = (state == arb_issue) && req_write;

    assign dram.le    = issue_rd && (req_target == tgt_dram);
    assign dram.we    = issue_wr && (req_target == tgt_dram);
    assign dram.size  = req_size;
    assign dram.addr  = req_addr;
    assign dram.wdata = req_wdata;

    assign io.le    = issue_rd && (req_target == tgt_io);
    assign io.we    = issue_wr && (req_target == tgt_io);
    assign io.size  = req_size;
    assign io.addr  = req_addr;
    assign io.wdata = req_wdata;

    // done goes to the chosen port only
    assign p0.done  = (state == arb_done) && !last_served;
    assign p1.done  = (state == arb_done) && last_served;
    assign p0.rdata = req_rdata;
    assign p1.rdata = req_rdata;

    assign grant = last_served;

endmodule

// File: verilog/core_port.sv
/* core port front end: captures rd/wr strobes, holds the request
   for the arbiter and returns read data with a busy level */

`timescale 1ns/100ps

module core_port import bus_pkg::*; (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              rd,
    input  logic              wr,
    input  target_t           target,
    input  acc_size_t         size,
    input  logic [addr_w-1:0] addr,
    input  logic [xlen-1:0]   wdata,
    output logic [xlen-1:0]   rdata,
    output logic              busy,
    port_if.front             bus
);

    logic              accept;
    logic              req_write;
    target_t           req_target;
    acc_size_t         req_size;
    logic [addr_w-1:0] req_addr;
    logic [xlen-1:0]   req_wdata;

    // strobes while busy are dropped
    assign accept = !busy && (rd || wr);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (busy && bus.done) begin
            busy <= 1'b0;
        end
    end

    // request fields, rd wins over wr
    always_ff @(posedge CLK) begin
        if (accept) begin
            req_write  <= !rd;
            req_target <= target;
            req_size   <= size;
            req_addr   <= addr;
            req_wdata  <= wdata;
        end
    end

    // load result held until the next read completes
    always_ff @(posedge CLK) begin
        if (busy && bus.done && !req_write) begin
            rdata <= bus.rdata;
        end
    end

    // pending for the whole time busy is up
    assign bus.pend     = busy;
    assign bus.is_write = req_write;
    assign bus.target   = req_target;
    assign bus.size     = req_size;
    assign bus.addr     = req_addr;
    assign bus.wdata    = req_wdata;

endmodule

// File: verilog/target_if.sv
/* strobe, busy and data signals between the arbiter and one shared target */

`timescale 1ns/100ps

interface target_if import bus_pkg::*; ();

    // load and write-enable strobes
    logic              le;
    logic              we;
    acc_size_t         size;
    logic [addr_w-1:0] addr;
    logic [xlen-1:0]   wdata;

    // busy level from the target, rdata valid once busy falls
    logic              busy;
    logic [xlen-1:0]   rdata;

    modport master (
        output le, we, size, addr, wdata,
        input  busy, rdata
    );

    modport slave (
        input  le, we, size, addr, wdata,
        output busy, rdata
    );

endinterface

// File: verilog/port_if.sv
/* request and completion signals between a core port and the arbiter */

`timescale 1ns/100ps

interface port_if import bus_pkg::*; ();

    // request side, held by the port until done
    logic              pend;
    logic              is_write;
    target_t           target;
    acc_size_t         size;
    logic [addr_w-1:0] addr;
    logic [xlen-1:0]   wdata;

    // completion, rdata valid with the done pulse
    logic              done;
    logic [xlen-1:0]   rdata;

    modport front (
        output pend, is_write, target, size, addr, wdata,
        input  done, rdata
    );

    modport arb (
        input  pend, is_write, target, size, addr, wdata,
        output done, rdata
    );

endinterface

// File: verilog/bus_pkg.sv
/* shared widths, access size and target enums, arbiter states */

package bus_pkg;

    // data and address widths
    localparam int xlen   = 32;
    localparam int addr_w = 32;

    // byte lanes per word
    localparam int lane_w = xlen / 8;

    // access size, low address bits pick the lane
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } acc_size_t;

    // shared target select
    typedef enum logic {
        tgt_dram = 1'b0,
        tgt_io   = 1'b1
    } target_t;

    // two-phase transfer
    typedef enum logic [1:0] {
        arb_idle  = 2'd0,
        arb_issue = 2'd1,  // strobe held until target busy rises
        arb_wait  = 2'd2,  // wait for target busy to fall
        arb_done  = 2'd3   // done pulse back to the port
    } arb_state_t;

endpackage
